/* all.f */
source/fencei_pkg.sv
source/wb_retire_intake.sv
source/fencei_flush_ctrl.sv
source/fetch_redirect_out.sv
source/fencei_protocol_monitor.sv
source/fencei_unit_top.sv
verif/fencei_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module fencei_unit_tb -o fencei_sim
out=$(./obj_dir/fencei_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

/* source/fencei_flush_ctrl.sv */
// Fence.i flush controller: drains outstanding data traffic, flushes the I-cache, then redirects
module fencei_flush_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     item_valid_i,
  input  fencei_pkg::retire_item_t item_i,
  output logic                     item_ready_o,
  input  fencei_pkg::data_bus_t    data_bus_i,
  output logic                     data_block_o,
  output logic                     flush_req_o,
  input  logic                     flush_ack_i,
  output logic                     redir_valid_o,
  output fencei_pkg::redirect_t    redir_o,
  input  logic                     redir_ready_i
);
  import fencei_pkg::*;

  flush_state_e       state_q;
  flush_state_e       state_d;
  logic [outst_w-1:0] outst_q;
  logic               bus_inc;
  logic               bus_dec;
  logic               item_take;
  logic               bus_idle;
  logic [xlen-1:0]    target_q;

  // A granted request opens a transaction, an rvalid closes one
  assign bus_inc = data_bus_i.req && data_bus_i.gnt && !data_bus_i.rvalid;
  assign bus_dec = data_bus_i.rvalid && !(data_bus_i.req && data_bus_i.gnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else if (bus_inc) begin
      outst_q <= outst_q + outst_w'(1);
    end else if (bus_dec) begin
      outst_q <= outst_q - outst_w'(1);
    end
  end

  // The bus is drained when nothing is in flight and no new grant is arriving
  assign bus_idle  = (outst_q == '0) && !(data_bus_i.req && data_bus_i.gnt);
  assign item_take = item_valid_i && item_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FL_IDLE: begin
        if (item_take && item_i.kind == INSTR_FENCEI) begin
          state_d = FL_DRAIN;
        end
      end
      FL_DRAIN: begin
        if (bus_idle) begin
          state_d = FL_FLUSH;
        end
      end
      FL_FLUSH: begin
        // Request drops in the cycle after the acknowledge
        if (flush_ack_i) begin
          state_d = FL_REDIRECT;
        end
      end
      FL_REDIRECT: begin
        if (redir_ready_i) begin
          state_d = FL_IDLE;
        end
      end
      default: begin
        state_d = FL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next fetch address is the word-aligned pc of the fence.i plus one instruction
  always_ff @(posedge clk_i) begin
    if (item_take && item_i.kind == INSTR_FENCEI) begin
      target_q <= {item_i.pc[xlen-1:2], 2'b00} + xlen'(4);
    end
  end

  assign item_ready_o   = (state_q == FL_IDLE);
  assign data_block_o   = (state_q == FL_DRAIN) || (state_q == FL_FLUSH);
  assign flush_req_o    = (state_q == FL_FLUSH);
  assign redir_valid_o  = (state_q == FL_REDIRECT);
  assign redir_o.target = target_q;

endmodule

/* source/fencei_pkg.sv */
// Fence.i unit shared definitions: widths, instruction encodings, state enums and bus structs
package fencei_pkg;

  // Data and address width
  localparam int xlen = 32;

  // MISC-MEM major opcode and the funct3 that selects fence.i within it
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [2:0] funct3_fencei = 3'b001;

  // Width of the outstanding data transaction counters
  localparam int outst_w = 3;

  typedef enum logic {
    INSTR_OTHER,
    INSTR_FENCEI
  } instr_kind_e;

  typedef enum logic [1:0] {
    FL_IDLE,
    FL_DRAIN,
    FL_FLUSH,
    FL_REDIRECT
  } flush_state_e;

  // Retired instruction as it arrives from writeback
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } retire_t;

  // Decoded retire item handed to the flush controller
  typedef struct packed {
    logic [xlen-1:0] pc;
    instr_kind_e     kind;
  } retire_item_t;

  typedef struct packed {
    logic [xlen-1:0] target;
  } redirect_t;

  // Observed load/store data bus traffic
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } data_bus_t;

  typedef struct packed {
    logic req_dropped_early;
    logic req_held_after_ack;
    logic data_req_during_flush;
    logic flush_with_outstanding;
  } monitor_flags_t;

endpackage

/* source/fencei_protocol_monitor.sv */
// Fence.i protocol monitor: sticky flags for flush handshake and data bus rule violations
module fencei_protocol_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_req_i,
  input  logic                       flush_ack_i,
  input  fencei_pkg::data_bus_t      data_bus_i,
  output fencei_pkg::monitor_flags_t flags_o
);
  import fencei_pkg::*;

  logic [outst_w-1:0] outst_q;
  logic               req_prev_q;
  logic               ack_prev_q;
  monitor_flags_t     flags_q;
  monitor_flags_t     hit;

  // Independent count of open data transactions, kept apart from the controller's
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else if (data_bus_i.req && data_bus_i.gnt && !data_bus_i.rvalid) begin
      outst_q <= outst_q + outst_w'(1);
    end else if (data_bus_i.rvalid && !(data_bus_i.req && data_bus_i.gnt)) begin
      outst_q <= outst_q - outst_w'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_prev_q <= 1'b0;
      ack_prev_q <= 1'b0;
    end else begin
      req_prev_q <= flush_req_i;
      ack_prev_q <= flush_ack_i;
    end
  end

  always_comb begin
    // Request went away although the cache never acknowledged it
    hit.req_dropped_early = req_prev_q && !ack_prev_q && !flush_req_i;
    // Request must be gone the cycle after the acknowledge
    hit.req_held_after_ack = req_prev_q && ack_prev_q && flush_req_i;
    hit.data_req_during_flush = flush_req_i && data_bus_i.req;
    // Checked on the rising edge of the request only
    hit.flush_with_outstanding = flush_req_i && !req_prev_q && (outst_q != '0);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_q | hit;
    end
  end

  assign flags_o = flags_q;

endmodule

/* source/fencei_unit_top.sv */
// Fence.i retirement unit top: intake, flush controller, fetch redirect output and protocol monitor
module fencei_unit_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       retire_req_i,
  input  fencei_pkg::retire_t        retire_i,
  output logic                       retire_ack_o,
  input  fencei_pkg::data_bus_t      data_bus_i,
  output logic                       data_block_o,
  output logic                       flush_req_o,
  input  logic                       flush_ack_i,
  output logic                       fetch_req_o,
  output fencei_pkg::redirect_t      fetch_redirect_o,
  input  logic                       fetch_ack_i,
  output fencei_pkg::monitor_flags_t monitor_flags_o
);
  import fencei_pkg::*;

  logic         item_valid;
  logic         item_ready;
  retire_item_t item;
  logic         redir_valid;
  logic         redir_ready;
  redirect_t    redir;

  wb_retire_intake wb_retire_intake_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .retire_req_i (retire_req_i),
    .retire_i     (retire_i),
    .retire_ack_o (retire_ack_o),
    .item_valid_o (item_valid),
    .item_o       (item),
    .item_ready_i (item_ready)
  );

  fencei_flush_ctrl fencei_flush_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .item_valid_i  (item_valid),
    .item_i        (item),
    .item_ready_o  (item_ready),
    .data_bus_i    (data_bus_i),
    .data_block_o  (data_block_o),
    .flush_req_o   (flush_req_o),
    .flush_ack_i   (flush_ack_i),
    .redir_valid_o (redir_valid),
    .redir_o       (redir),
    .redir_ready_i (redir_ready)
  );

  fetch_redirect_out fetch_redirect_out_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .redir_valid_i    (redir_valid),
    .redir_i          (redir),
    .redir_ready_o    (redir_ready),
    .fetch_req_o      (fetch_req_o),
    .fetch_redirect_o (fetch_redirect_o),
    .fetch_ack_i      (fetch_ack_i)
  );

  // The monitor sees the flush wires as they leave the unit and the raw bus
  fencei_protocol_monitor fencei_protocol_monitor_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_req_i (flush_req_o),
    .flush_ack_i (flush_ack_i),
    .data_bus_i  (data_bus_i),
    .flags_o     (monitor_flags_o)
  );

endmodule

/* source/fetch_redirect_out.sv */
// Fetch redirect output: holds one redirect and drives the four-phase master handshake to fetch
module fetch_redirect_out (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  redir_valid_i,
  input  fencei_pkg::redirect_t redir_i,
  output logic                  redir_ready_o,
  output logic                  fetch_req_o,
  output fencei_pkg::redirect_t fetch_redirect_o,
  input  logic                  fetch_ack_i
);
  import fencei_pkg::*;

  logic      req_q;
  redirect_t redir_q;
  logic      load;

  // A new redirect is taken only once the previous four-phase cycle has fully closed
  assign redir_ready_o = !req_q && !fetch_ack_i;
  assign load          = redir_valid_i && redir_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (load) begin
      req_q <= 1'b1;
    end else if (req_q && fetch_ack_i) begin
      req_q <= 1'b0;
    end
  end

  // Target stays stable for the whole time the request is up
  always_ff @(posedge clk_i) begin
    if (load) begin
      redir_q <= redir_i;
    end
  end

  assign fetch_req_o      = req_q;
  assign fetch_redirect_o = redir_q;

endmodule

/* source/wb_retire_intake.sv */
// Retire intake: four-phase slave handshake from writeback with a one-entry buffer and fence.i decode
module wb_retire_intake (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    retire_req_i,
  input  fencei_pkg::retire_t     retire_i,
  output logic                    retire_ack_o,
  output logic                    item_valid_o,
  output fencei_pkg::retire_item_t item_o,
  input  logic                    item_ready_i
);
  import fencei_pkg::*;

  logic         ack_q;
  logic         buf_valid_q;
  retire_item_t buf_q;
  instr_kind_e  kind_dec;
  logic         capture;
  logic         take;

  // Only opcode and funct3 matter, imm, rs1 and rd are reserved for fence.i
  always_comb begin
    if (retire_i.instr[6:0] == opc_misc_mem && retire_i.instr[14:12] == funct3_fencei) begin
      kind_dec = INSTR_FENCEI;
    end else begin
      kind_dec = INSTR_OTHER;
    end
  end

  // A new request is captured only when the previous phase is closed and the buffer is free
  assign capture = retire_req_i && !ack_q && !buf_valid_q;
  assign take    = buf_valid_q && item_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (capture) begin
        ack_q <= 1'b1;
      end else if (ack_q && !retire_req_i) begin
        ack_q <= 1'b0;
      end
      if (capture) begin
        buf_valid_q <= 1'b1;
      end else if (take) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      buf_q.pc   <= retire_i.pc;
      buf_q.kind <= kind_dec;
    end
  end

  assign retire_ack_o = ack_q;
  assign item_valid_o = buf_valid_q;
  assign item_o       = buf_q;

endmodule

/* verif/fencei_unit_tb.sv */
// Fence.i unit testbench that drives retires, models cache, fetch and load/store bus, and checks redirects
module fencei_unit_tb;
  import fencei_pkg::*;

  logic           clk_i = 1'b0;
  logic           rst_ni;
  logic           retire_req_i;
  retire_t        retire_i;
  logic           retire_ack_o;
  data_bus_t      data_bus_i = '0;
  logic           data_block_o;
  logic           flush_req_o;
  logic           flush_ack_i = 1'b0;
  logic           fetch_req_o;
  redirect_t      fetch_redirect_o;
  logic           fetch_ack_i = 1'b0;
  monitor_flags_t monitor_flags_o;

  // LSU mode 0 is idle, 1 issues random traffic and obeys data_block_o, 2 raises req in a flush
  int lsu_mode;
  int lsu_rate;
  int lsu_dmin;
  int lsu_dmax;
  int cache_max;
  int fetch_max;

  int lsu_outst = 0;
  int lsu_pend[$];
  int cache_wait = -1;
  int fetch_wait = -1;

  redirect_t exp_q[$];
  int        exp_rd = 0;
  int        redir_count = 0;
  int        redir_errors = 0;
  logic      fetch_req_prev = 1'b0;
  int        errors;
  int        tests_failed;

  always #5 clk_i = ~clk_i;

  fencei_unit_top fencei_unit_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .retire_req_i     (retire_req_i),
    .retire_i         (retire_i),
    .retire_ack_o     (retire_ack_o),
    .data_bus_i       (data_bus_i),
    .data_block_o     (data_block_o),
    .flush_req_o      (flush_req_o),
    .flush_ack_i      (flush_ack_i),
    .fetch_req_o      (fetch_req_o),
    .fetch_redirect_o (fetch_redirect_o),
    .fetch_ack_i      (fetch_ack_i),
    .monitor_flags_o  (monitor_flags_o)
  );

  // Fence.i is MISC-MEM with funct3 001 and every other field is don't care
  function automatic instr_kind_e ref_decode(input retire_t r, output redirect_t tgt);
    tgt.target = (r.pc & ~32'h3) + 32'd4;
    if (r.instr[6:0] == opc_misc_mem && r.instr[14:12] == funct3_fencei) begin
      return INSTR_FENCEI;
    end
    return INSTR_OTHER;
  endfunction

  function automatic retire_t make_instr(input bit fencei);
    retire_t r;
    r.pc    = $urandom;
    r.instr = $urandom;
    if (fencei) begin
      r.instr[6:0]   = opc_misc_mem;
      r.instr[14:12] = funct3_fencei;
    end else if ($urandom_range(0, 3) == 0) begin
      // Plain fence shares the opcode and must not flush
      r.instr[6:0]   = opc_misc_mem;
      r.instr[14:12] = 3'b000;
    end
    return r;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp, inout int err);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
      err++;
    end
  endtask

  task automatic check_redirect(input string name, input redirect_t got, input redirect_t exp,
                                inout int err);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got.target, exp.target);
      err++;
    end
  endtask

  task automatic check_flags(input monitor_flags_t got, input monitor_flags_t exp, inout int err);
    if (got !== exp) begin
      $display("Fail at time %0t: monitor_flags_o is %b, expected %b", $time, got, exp);
      err++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at time %0t while waiting for %s", $time, what);
    errors++;
  endtask

  // Four-phase master side of the retire handshake, entered and left on a falling edge
  task automatic drive_retire(input retire_t r);
    redirect_t tgt;
    int        cnt;
    if (ref_decode(r, tgt) == INSTR_FENCEI) begin
      exp_q.push_back(tgt);
    end
    retire_req_i = 1'b1;
    retire_i     = r;
    cnt = 0;
    while (!retire_ack_o && cnt < 500) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!retire_ack_o) begin
      report_timeout("retire_ack_o to rise");
    end
    retire_req_i = 1'b0;
    cnt = 0;
    while (retire_ack_o && cnt < 50) begin
      @(negedge clk_i);
      cnt++;
    end
    if (retire_ack_o) begin
      report_timeout("retire_ack_o to fall");
    end
  endtask

  task automatic wait_drained(input string what);
    int cnt;
    cnt = 0;
    while (!(redir_count == exp_q.size() && !fetch_req_o && !fetch_ack_i && !flush_req_o &&
             !data_block_o && lsu_outst == 0 && !retire_ack_o) && cnt < 3000) begin
      @(negedge clk_i);
      cnt++;
    end
    if (cnt >= 3000) begin
      report_timeout(what);
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    int diff;
    diff = errors + redir_errors - err_before;
    if (diff == 0) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: failed with %0d error(s)", num, name, diff);
      tests_failed++;
    end
  endtask

  // Load/store bus model with in-order responses
  always @(negedge clk_i) begin : lsu_model
    data_bus_t bus_next;
    int        inc;
    int        dec;
    bus_next = '0;
    inc = 0;
    dec = 0;
    if (!rst_ni) begin
      lsu_pend.delete();
      data_bus_i <= '0;
      lsu_outst  <= 0;
    end else begin
      if (lsu_pend.size() > 0) begin
        if (lsu_pend[0] == 0) begin
          bus_next.rvalid = 1'b1;
          void'(lsu_pend.pop_front());
          dec = 1;
        end else begin
          lsu_pend[0] = lsu_pend[0] - 1;
        end
      end
      if (lsu_mode == 1 && !data_block_o && lsu_pend.size() < 3 &&
          int'($urandom_range(0, 99)) < lsu_rate) begin
        bus_next.req = 1'b1;
        bus_next.gnt = 1'b1;
        lsu_pend.push_back(int'($urandom_range(lsu_dmin, lsu_dmax)));
        inc = 1;
      end
      // The bus never grants this request, so no transaction opens
      if (lsu_mode == 2 && flush_req_o) begin
        bus_next.req = 1'b1;
      end
      data_bus_i <= bus_next;
      lsu_outst  <= lsu_outst + inc - dec;
    end
  end

  // I-cache acknowledges each flush request with a one-cycle pulse after a random delay
  always @(negedge clk_i) begin : cache_model
    if (!rst_ni) begin
      flush_ack_i <= 1'b0;
      cache_wait = -1;
    end else if (flush_ack_i) begin
      flush_ack_i <= 1'b0;
    end else if (flush_req_o) begin
      if (cache_wait < 0) begin
        cache_wait = int'($urandom_range(0, cache_max));
      end
      if (cache_wait == 0) begin
        flush_ack_i <= 1'b1;
        cache_wait = -1;
      end else begin
        cache_wait = cache_wait - 1;
      end
    end
  end

  always @(negedge clk_i) begin : fetch_model
    if (!rst_ni) begin
      fetch_ack_i <= 1'b0;
      fetch_wait = -1;
    end else if (fetch_req_o && !fetch_ack_i) begin
      if (fetch_wait < 0) begin
        fetch_wait = int'($urandom_range(0, fetch_max));
      end
      if (fetch_wait == 0) begin
        fetch_ack_i <= 1'b1;
        fetch_wait = -1;
      end else begin
        fetch_wait = fetch_wait - 1;
      end
    end else if (!fetch_req_o && fetch_ack_i) begin
      fetch_ack_i <= 1'b0;
    end
  end

  // Each rising fetch request is one redirect and is matched against the retire order
  always @(negedge clk_i) begin : redirect_checker
    if (!rst_ni) begin
      fetch_req_prev <= 1'b0;
    end else begin
      if (fetch_req_o && !fetch_req_prev) begin
        if (exp_rd >= exp_q.size()) begin
          $display("Unexpected fetch redirect to %h at time %0t", fetch_redirect_o.target, $time);
          redir_errors = redir_errors + 1;
        end else begin
          check_redirect("fetch_redirect_o", fetch_redirect_o, exp_q[exp_rd], redir_errors);
          exp_rd <= exp_rd + 1;
        end
        redir_count <= redir_count + 1;
      end
      fetch_req_prev <= fetch_req_o;
    end
  end

  initial begin
    int unsigned    seed;
    retire_t        r;
    monitor_flags_t flags_exp;
    int             err_before;
    int             cnt;
    seed = $urandom(32'haad0_258a);
    errors       = 0;
    tests_failed = 0;
    rst_ni       = 1'b0;
    retire_req_i = 1'b0;
    retire_i     = '0;
    lsu_mode     = 0;
    lsu_rate     = 50;
    lsu_dmin     = 0;
    lsu_dmax     = 6;
    cache_max    = 2;
    fetch_max    = 3;
    for (cnt = 0; cnt < 5; cnt++) begin
      @(negedge clk_i);
    end
    rst_ni = 1'b1;

    err_before = errors + redir_errors;
    check_bit("retire_ack_o", retire_ack_o, 1'b0, errors);
    check_bit("flush_req_o", flush_req_o, 1'b0, errors);
    check_bit("data_block_o", data_block_o, 1'b0, errors);
    check_bit("fetch_req_o", fetch_req_o, 1'b0, errors);
    check_flags(monitor_flags_o, '0, errors);
    r.pc    = 32'h0000_1000;
    r.instr = 32'h0000_100f;
    drive_retire(r);
    r.pc    = 32'h0000_2003;
    r.instr = 32'hfff0_900f;
    drive_retire(r);
    r.pc    = 32'hffff_fffe;
    drive_retire(r);
    wait_drained("test 1 redirects");
    if (redir_count != 3) begin
      $display("Test 1 saw %0d redirects for 3 fence.i instructions", redir_count);
      errors++;
    end
    check_flags(monitor_flags_o, '0, errors);
    report_test(1, "fence.i on idle bus", err_before);

    // Long response delays keep the bus busy while the fence.i drains
    err_before = errors + redir_errors;
    lsu_mode = 1;
    lsu_rate = 100;
    lsu_dmin = 8;
    lsu_dmax = 15;
    cnt = 0;
    while (lsu_outst < 2 && cnt < 50) begin
      @(negedge clk_i);
      cnt++;
    end
    if (lsu_outst < 2) begin
      report_timeout("data transactions to be outstanding");
    end
    drive_retire(make_instr(1'b1));
    cnt = 0;
    while (!flush_req_o && cnt < 200) begin
      @(negedge clk_i);
      cnt++;
      check_bit("data_block_o", data_block_o, 1'b1, errors);
      if (lsu_outst != 0) begin
        check_bit("flush_req_o", flush_req_o, 1'b0, errors);
      end
    end
    if (!flush_req_o) begin
      report_timeout("flush_req_o after the drain");
    end
    lsu_mode = 0;
    wait_drained("test 2 redirect");
    check_flags(monitor_flags_o, '0, errors);
    report_test(2, "fence.i with outstanding data", err_before);

    err_before = errors + redir_errors;
    lsu_mode = 1;
    lsu_rate = 40;
    lsu_dmin = 0;
    lsu_dmax = 6;
    for (cnt = 0; cnt < 40; cnt++) begin
      drive_retire(make_instr($urandom_range(0, 99) < 40));
    end
    lsu_mode = 0;
    wait_drained("test 3 redirects");
    check_flags(monitor_flags_o, '0, errors);
    report_test(3, "random instruction mix", err_before);

    err_before = errors + redir_errors;
    lsu_mode  = 1;
    cache_max = 5;
    fetch_max = 12;
    for (cnt = 0; cnt < 24; cnt++) begin
      drive_retire(make_instr($urandom_range(0, 99) < 75));
    end
    lsu_mode = 0;
    wait_drained("test 4 redirects");
    check_flags(monitor_flags_o, '0, errors);
    report_test(4, "slow cache and fetch", err_before);

    err_before = errors + redir_errors;
    lsu_mode  = 2;
    flags_exp = '0;
    flags_exp.data_req_during_flush = 1'b1;
    drive_retire(make_instr(1'b1));
    wait_drained("test 5 redirect");
    check_flags(monitor_flags_o, flags_exp, errors);
    // The flag is sticky and must survive later traffic
    drive_retire(make_instr(1'b0));
    wait_drained("test 5 follow-up retire");
    check_flags(monitor_flags_o, flags_exp, errors);
    report_test(5, "data request during flush", err_before);

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors + redir_errors);
    if (errors + redir_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
